//--- Bender.yml
package:
  name: blimp_cluster

export_include_dirs:
  - source

sources:
  - source/blimp_pkg.sv
  - source/issue_unit.sv
  - source/exec_lane.sv
  - source/commit_unit.sv
  - source/blimp_cluster.sv
  - target: test
    files:
      - verif/tb_blimp_cluster.sv

//--- flist.f
+incdir+source
source/blimp_pkg.sv
source/issue_unit.sv
source/exec_lane.sv
source/commit_unit.sv
source/blimp_cluster.sv
verif/tb_blimp_cluster.sv

//--- source/blimp_cluster.sv
//--------------------------------------------------------------------
// Execution cluster top level
// Issue unit, generated execute lanes and commit unit
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "blimp_params.svh"

module blimp_cluster (
  input  logic                clk,
  input  logic                arst_n,

  input  logic                inst_valid,
  output logic                inst_ready,
  input  blimp_pkg::inst_t    inst,

  output logic                commit_valid,
  output blimp_pkg::commit_t  commit
);

  import blimp_pkg::*;

  issue_t                 issue;
  logic [`NUM_LANES-1:0]  issue_valid;
  logic [`NUM_LANES-1:0]  lane_idle;
  logic [`NUM_LANES-1:0]  res_valid;
  logic [`NUM_LANES-1:0]  res_ready;
  result_t                lane_res [`NUM_LANES];

  //------------------------------------------------------------------
  // Units
  //------------------------------------------------------------------

  issue_unit IU (
    .issue_valid (issue_valid),
    .issue       (issue),
    .lane_idle   (lane_idle),
    .*
  );

  // Lanes share the issue payload, each has its own valid
  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    exec_lane XU (
      .clk         (clk),
      .arst_n      (arst_n),
      .issue_valid (issue_valid[i]),
      .idle        (lane_idle[i]),
      .issue       (issue),
      .res_valid   (res_valid[i]),
      .res_ready   (res_ready[i]),
      .res         (lane_res[i])
    );
  end

  commit_unit CU (
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (lane_res),
    .*
  );

endmodule

//--- source/blimp_params.svh
//--------------------------------------------------------------------
// Cluster sizing macros
// Lane count, sequence width, register count, data width, MUL latency
//--------------------------------------------------------------------

`ifndef BLIMP_PARAMS_SVH
`define BLIMP_PARAMS_SVH

// Identical execute lanes
`define NUM_LANES  4

// Sequence number width, reorder buffer holds 2**SEQ_BITS entries
`define SEQ_BITS   4

`define NUM_REGS   32  // Register 0 reads zero
`define XLEN       32  // Datapath width
`define MUL_CYCLES 4   // Iterative multiply latency

`endif // BLIMP_PARAMS_SVH

//--- source/blimp_pkg.sv
//--------------------------------------------------------------------
// Shared types for the execution cluster
// Opcodes and the structs passed between issue, lanes and commit
//--------------------------------------------------------------------

`include "blimp_params.svh"

package blimp_pkg;

  typedef logic [`XLEN-1:0]              data_t;
  typedef logic [`SEQ_BITS-1:0]          seq_t;
  typedef logic [$clog2(`NUM_REGS)-1:0]  reg_t;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,   // Signed compare
    OP_SLL,   // Shift by low 5 bits of b
    OP_MUL,   // Low half of product
    OP_LI     // rd = imm
  } op_e;

  //------------------------------------------------------------------
  // Stage payloads
  //------------------------------------------------------------------

  typedef struct packed {
    op_e   op;
    reg_t  rd;
    reg_t  rs1;
    reg_t  rs2;
    data_t imm;
  } inst_t;

  typedef struct packed {
    op_e   op;
    seq_t  seq;
    reg_t  waddr;
    logic  wen;
    data_t op_a;
    data_t op_b;    // Holds imm for LI
  } issue_t;

  typedef struct packed {
    seq_t  seq;
    reg_t  waddr;
    logic  wen;
    data_t wdata;
  } result_t;

  // Retirement notification
  typedef struct packed {
    seq_t  seq;
    reg_t  waddr;
    logic  wen;
    data_t wdata;
  } commit_t;

endpackage

//--- source/commit_unit.sv
//--------------------------------------------------------------------
// Commit unit
// Lane arbiter, reorder buffer and in-order retirement
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "blimp_params.svh"

module commit_unit (
  input  logic                   clk,
  input  logic                   arst_n,

  input  logic [`NUM_LANES-1:0]  res_valid,
  output logic [`NUM_LANES-1:0]  res_ready,
  input  blimp_pkg::result_t     res [`NUM_LANES],

  output logic                   commit_valid,
  output blimp_pkg::commit_t     commit
);

  import blimp_pkg::*;

  localparam int ROB_SIZE = 1 << `SEQ_BITS;

  logic [`NUM_LANES-1:0]  grant;
  logic                   win_valid;
  result_t                win;
  logic [ROB_SIZE-1:0]    rob_done;
  result_t                rob_data [ROB_SIZE];
  seq_t                   head;
  result_t                head_ent;

  //------------------------------------------------------------------
  // Fixed-priority arbiter, lane 0 wins
  //------------------------------------------------------------------

  assign grant     = res_valid & (~res_valid + 1'b1);
  assign res_ready = grant;
  assign win_valid = |grant;

  always_comb begin
    win = '0;
    for (int i = 0; i < `NUM_LANES; i++) begin
      if (grant[i]) begin
        win = res[i];
      end
    end
  end

  //------------------------------------------------------------------
  // Reorder buffer
  //------------------------------------------------------------------

  // Payload indexed by sequence number
  always_ff @(posedge clk) begin
    if (win_valid) begin
      rob_data[win.seq] <= win;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rob_done <= '0;
      head     <= '0;
    end else begin
      if (commit_valid) begin
        rob_done[head] <= 1'b0;
        head           <= head + 1'b1;
      end
      if (win_valid) begin
        rob_done[win.seq] <= 1'b1;
      end
    end
  end

  //------------------------------------------------------------------
  // Retirement
  //------------------------------------------------------------------

  assign head_ent     = rob_data[head];
  assign commit_valid = rob_done[head];   // Head entry done

  always_comb begin
    commit.seq   = head_ent.seq;
    commit.waddr = head_ent.waddr;
    commit.wen   = head_ent.wen;
    commit.wdata = head_ent.wdata;
  end

  // Sequence numbers from issue never overrun a live entry
  assert property (@(posedge clk) disable iff (!arst_n)
    win_valid |-> !rob_done[win.seq]);

endmodule

//--- source/exec_lane.sv
//--------------------------------------------------------------------
// Execute lane
// Single-cycle ALU, iterative multiply, result held until taken
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "blimp_params.svh"

module exec_lane (
  input  logic                clk,
  input  logic                arst_n,

  input  logic                issue_valid,
  output logic                idle,
  input  blimp_pkg::issue_t   issue,

  output logic                res_valid,
  input  logic                res_ready,
  output blimp_pkg::result_t  res
);

  import blimp_pkg::*;

  localparam int XLEN  = `XLEN;
  localparam int CHUNK = `XLEN / `MUL_CYCLES;   // Multiplier bits per cycle
  localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

  typedef enum logic [1:0] {S_IDLE, S_BUSY, S_HOLD} state_e;

  state_e              state;
  logic [CNT_W-1:0]    cnt;
  issue_t              iss_q;
  data_t               acc_q;
  data_t               mul_sum;
  data_t               alu_out;
  result_t             res_q;
  logic                last;

  assign last = (state == S_BUSY) && (cnt == '0);

  // One partial product per cycle
  assign mul_sum = acc_q + XLEN'(iss_q.op_a * iss_q.op_b[CHUNK-1:0]);

  always_comb begin
    case (iss_q.op)
      OP_ADD:  alu_out = iss_q.op_a + iss_q.op_b;
      OP_SUB:  alu_out = iss_q.op_a - iss_q.op_b;
      OP_AND:  alu_out = iss_q.op_a & iss_q.op_b;
      OP_OR:   alu_out = iss_q.op_a | iss_q.op_b;
      OP_XOR:  alu_out = iss_q.op_a ^ iss_q.op_b;
      OP_SLT:  alu_out = data_t'($signed(iss_q.op_a) < $signed(iss_q.op_b));
      OP_SLL:  alu_out = iss_q.op_a << iss_q.op_b[4:0];
      OP_LI:   alu_out = iss_q.op_b;
      default: alu_out = '0;
    endcase
  end

  //------------------------------------------------------------------
  // Lane FSM
  //------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: if (issue_valid) begin
          state <= S_BUSY;
          cnt   <= (issue.op == OP_MUL) ? CNT_W'(`MUL_CYCLES - 1) : '0;
        end
        S_BUSY: if (cnt == '0) begin
          state <= S_HOLD;
        end else begin
          cnt <= cnt - 1'b1;
        end
        S_HOLD: if (res_ready) begin
          state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Operands and result
  always_ff @(posedge clk) begin
    if (state == S_IDLE && issue_valid) begin
      iss_q <= issue;
      acc_q <= '0;
    end else if (state == S_BUSY && iss_q.op == OP_MUL) begin
      acc_q      <= mul_sum;
      iss_q.op_a <= iss_q.op_a << CHUNK;
      iss_q.op_b <= iss_q.op_b >> CHUNK;   // Next multiplier chunk
    end
    if (last) begin
      res_q.seq   <= iss_q.seq;
      res_q.waddr <= iss_q.waddr;
      res_q.wen   <= iss_q.wen;
      res_q.wdata <= (iss_q.op == OP_MUL) ? mul_sum : alu_out;
    end
  end

  assign idle      = (state == S_IDLE);
  assign res_valid = (state == S_HOLD);
  assign res       = res_q;

  // Stalled result must not change
  assert property (@(posedge clk) disable iff (!arst_n)
    res_valid && !res_ready |=> res_valid && $stable(res));

endmodule

//--- source/issue_unit.sv
//--------------------------------------------------------------------
// Issue unit
// Scoreboard, register file, sequence numbering and lane dispatch
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "blimp_params.svh"

module issue_unit (
  input  logic                   clk,
  input  logic                   arst_n,

  input  logic                   inst_valid,
  output logic                   inst_ready,
  input  blimp_pkg::inst_t       inst,

  input  logic [`NUM_LANES-1:0]  lane_idle,
  output logic [`NUM_LANES-1:0]  issue_valid,
  output blimp_pkg::issue_t      issue,

  input  logic                   commit_valid,
  input  blimp_pkg::commit_t     commit
);

  import blimp_pkg::*;

  localparam int ROB_SIZE = 1 << `SEQ_BITS;

  data_t                   rf [`NUM_REGS];
  logic [`NUM_REGS-1:0]    pending;       // Scoreboard, one bit per register
  seq_t                    seq_q;
  logic [`SEQ_BITS:0]      in_flight;
  logic                    live;
  logic                    uses_rs;
  logic                    hazard;
  logic                    full;
  logic [`NUM_LANES-1:0]   lane_pick;
  logic                    fire;
  data_t                   rs1_data;
  data_t                   rs2_data;

  //------------------------------------------------------------------
  // Register file
  //------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (commit_valid && commit.wen) begin
      rf[commit.waddr] <= commit.wdata;
    end
  end

  assign rs1_data = (inst.rs1 == '0) ? '0 : rf[inst.rs1];
  assign rs2_data = (inst.rs2 == '0) ? '0 : rf[inst.rs2];

  //------------------------------------------------------------------
  // Hazards and dispatch
  //------------------------------------------------------------------

  assign uses_rs = (inst.op != OP_LI);   // LI reads no source registers

  assign hazard = (uses_rs && (pending[inst.rs1] || pending[inst.rs2])) ||
                  ((inst.rd != '0) && pending[inst.rd]);

  assign full = (in_flight == ROB_SIZE);

  // Lowest idle lane as a one-hot vector
  assign lane_pick = lane_idle & (~lane_idle + 1'b1);

  assign inst_ready = live && !hazard && !full && (|lane_idle);
  assign fire       = inst_valid && inst_ready;

  assign issue_valid = fire ? lane_pick : '0;

  always_comb begin
    issue.op    = inst.op;
    issue.seq   = seq_q;
    issue.waddr = inst.rd;
    issue.wen   = (inst.rd != '0);
    issue.op_a  = rs1_data;
    issue.op_b  = (inst.op == OP_LI) ? inst.imm : rs2_data;  // Fold imm for LI
  end

  //------------------------------------------------------------------
  // Control state
  //------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending   <= '0;
      seq_q     <= '0;
      in_flight <= '0;
      live      <= 1'b0;
    end else begin
      live <= 1'b1;   // Accepting starts one edge after reset

      // A new rd is never the retiring register
      if (commit_valid && commit.wen) begin
        pending[commit.waddr] <= 1'b0;
      end
      if (fire && issue.wen) begin
        pending[inst.rd] <= 1'b1;
      end

      if (fire) begin
        seq_q <= seq_q + 1'b1;
      end

      case ({fire, commit_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Each retirement belongs to an outstanding instruction still on the scoreboard
  assert property (@(posedge clk) disable iff (!arst_n)
    commit_valid |-> (in_flight != '0) && (!commit.wen || pending[commit.waddr]));

endmodule

//--- verif/tb_blimp_cluster.sv
//--------------------------------------------------------------------
// Testbench for the execution cluster
// Random and directed instruction streams, program-order register model
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "blimp_params.svh"

module tb_blimp_cluster;

  import blimp_pkg::*;

  localparam int WAIT_LIMIT  = 200;    // Cycles for one acceptance
  localparam int DRAIN_LIMIT = 2000;   // Cycles to retire all in flight

  logic     clk;
  logic     arst_n;
  logic     inst_valid;
  logic     inst_ready;
  inst_t    inst;
  logic     commit_valid;
  commit_t  commit;

  integer   seed = 32'hddb8;
  int       errors;
  int       checks;
  int       accepts;
  int       commits;
  seq_t     next_seq;
  inst_t    exp_q [$];   // Accepted but not yet retired
  seq_t     seq_q [$];
  data_t    model_rf [`NUM_REGS];
  inst_t    in_c;
  commit_t  exp_c;

  blimp_cluster UUT (.*);

  always #5 clk = ~clk;

  //------------------------------------------------------------------
  // Compare tasks
  //------------------------------------------------------------------

  task automatic check_commit(input commit_t got, input commit_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: commit got seq %0d r%0d wen %b %h, expected seq %0d r%0d wen %b %h",
               $time, got.seq, got.waddr, got.wen, got.wdata,
               exp.seq, exp.waddr, exp.wen, exp.wdata);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s at %0t", why, $time);
    $display("Test failed");
    $finish;
  endtask

  //------------------------------------------------------------------
  // Reference model
  //------------------------------------------------------------------

  function automatic data_t alu_model(input op_e op, input data_t a, input data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLL:  return a << b[4:0];
      OP_MUL:  return a * b;   // Low 32 bits only
      default: return b;       // LI
    endcase
  endfunction

  // Retires one instruction against the model register file
  function automatic commit_t model_commit(input inst_t in, input seq_t s);
    commit_t c;
    data_t   a;
    data_t   b;
    a = (in.rs1 == '0) ? '0 : model_rf[in.rs1];
    b = (in.op == OP_LI) ? in.imm : ((in.rs2 == '0) ? '0 : model_rf[in.rs2]);
    c.seq   = s;
    c.waddr = in.rd;
    c.wen   = (in.rd != '0);
    c.wdata = alu_model(in.op, a, b);
    if (c.wen) model_rf[in.rd] = c.wdata;
    return c;
  endfunction

  // Commit outputs only move at posedge
  always @(negedge clk) begin
    if (arst_n && commit_valid) begin
      commits++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Commit seen with nothing outstanding at %0t", $time);
      end else begin
        in_c  = exp_q.pop_front();
        exp_c = model_commit(in_c, seq_q.pop_front());
        check_commit(commit, exp_c);
      end
    end
  end

  //------------------------------------------------------------------
  // Stimulus helpers
  //------------------------------------------------------------------

  function automatic inst_t make_inst(input op_e op, input int rd, input int rs1,
                                      input int rs2, input data_t imm);
    inst_t in;
    in.op  = op;
    in.rd  = reg_t'(rd);
    in.rs1 = reg_t'(rs1);
    in.rs2 = reg_t'(rs2);
    in.imm = imm;
    return in;
  endfunction

  // Registers 0..8 only so that reads never hit unwritten entries
  function automatic inst_t rand_inst();
    logic [31:0] r;
    logic [3:0]  code;
    r    = $random(seed);
    code = 4'(r[7:0] % 9);
    return make_inst(op_e'(code), r[15:8] % 9, r[23:16] % 9, r[31:24] % 9, $random(seed));
  endfunction

  // Returns at the negedge after the transfer
  task automatic send_inst(input inst_t in);
    int t;
    inst_valid = 1'b1;
    inst       = in;
    #1;
    for (t = 0; !inst_ready; t++) begin
      if (t == WAIT_LIMIT) abort_run("Timeout waiting for inst_ready");
      @(negedge clk);
      #1;
    end
    exp_q.push_back(in);
    seq_q.push_back(next_seq);
    next_seq++;
    accepts++;
    @(negedge clk);
  endtask

  task automatic drain();
    int t;
    inst_valid = 1'b0;
    for (t = 0; exp_q.size() != 0; t++) begin
      if (t == DRAIN_LIMIT) abort_run("Timeout waiting for outstanding commits");
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input int num, input string name, input int err0);
    drain();
    $display("[%0d] %s done, %0d errors", num, name, errors - err0);
  endtask

  //------------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------------

  initial begin
    int e0;
    int a0;
    int c0;
    clk        = 1'b0;
    arst_n     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    errors     = 0;
    checks     = 0;
    accepts    = 0;
    commits    = 0;
    next_seq   = '0;
    foreach (model_rf[i]) model_rf[i] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    e0 = errors;   // Idle after reset
    #1;
    check_bit(inst_ready, 1'b0, "inst_ready after reset");
    check_bit(commit_valid, 1'b0, "commit_valid after reset");
    repeat (5) begin
      @(negedge clk);
      check_bit(commit_valid, 1'b0, "commit_valid with no input");
    end
    $display("[1] reset idle done, %0d errors", errors - e0);

    e0 = errors;
    for (int i = 0; i < 8; i++) send_inst(make_inst(OP_LI, i + 1, 0, 0, $random(seed)));
    for (int i = 0; i < 300; i++) send_inst(rand_inst());
    finish_test(2, "random ops", e0);

    e0 = errors;   // Slow MUL ahead of fast ALU ops
    send_inst(make_inst(OP_MUL, 1, 2, 3, '0));
    send_inst(make_inst(OP_ADD, 4, 5, 6, '0));
    send_inst(make_inst(OP_XOR, 7, 5, 6, '0));
    send_inst(make_inst(OP_SUB, 8, 6, 5, '0));
    finish_test(3, "mul then alu order", e0);

    e0 = errors;
    send_inst(make_inst(OP_LI, 10, 0, 0, 32'd3));
    send_inst(make_inst(OP_ADD, 11, 10, 10, '0));
    send_inst(make_inst(OP_MUL, 12, 11, 11, '0));
    send_inst(make_inst(OP_SLL, 10, 12, 11, '0));
    send_inst(make_inst(OP_SLT, 11, 10, 12, '0));
    finish_test(4, "dependent chain", e0);

    e0 = errors;
    send_inst(make_inst(OP_LI, 0, 0, 0, 32'hdead_beef));
    send_inst(make_inst(OP_ADD, 9, 0, 0, '0));
    send_inst(make_inst(OP_OR, 9, 9, 0, '0));
    finish_test(5, "register zero", e0);

    e0 = errors;   // inst_valid stays high across the burst
    a0 = accepts;
    c0 = commits;
    for (int i = 0; i < 20; i++) begin
      send_inst(make_inst(OP_MUL, {$random(seed)} % 12 + 1, {$random(seed)} % 12 + 1,
                          {$random(seed)} % 12 + 1, '0));
    end
    drain();
    // Quiet window where a duplicate commit would surface
    repeat (2 * `MUL_CYCLES) begin
      @(negedge clk);
      check_bit(commit_valid, 1'b0, "commit_valid after burst drained");
    end
    check_count(commits - c0, accepts - a0, "burst commit count");
    finish_test(6, "mul burst", e0);

    $display("Checks %0d, errors %0d, accepted %0d, committed %0d",
             checks, errors, accepts, commits);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
